/* verilog/cfi_defs.svh */
`ifndef CFI_DEFS_SVH
`define CFI_DEFS_SVH

// address and data width of the monitored core
`define CFI_XLEN 32

// number of return addresses the shadow stack can hold
`define CFI_SS_DEPTH 8

// cycles an exception record stays valid once raised
`define CFI_EX_HOLD 12

// marker nop layout: low two immediate bits carry the tag,
// bits 10..2 carry the argument count and bit 11 flags a variadic callee
`define CFI_NOP_IMM_TAG 2'd2
`define CFI_ARGS_W 9
`define CFI_NOP_ARGS_LSB 2
`define CFI_NOP_VARIADIC_BIT 11

`endif

/* verilog/cfi_pkg.sv */
`default_nettype none

`include "cfi_defs.svh"

package cfi_pkg;

   typedef logic [`CFI_XLEN-1:0]   addr_t;
   typedef logic [4:0]             reg_idx_t;
   typedef logic [11:0]            imm_t;
   // all ones means no indirect call is pending
   typedef logic [`CFI_ARGS_W-1:0] nargs_t;

   typedef enum logic [1:0] {
      OP_ADD,
      OP_JAL,
      OP_JALR,
      OP_OTHER
   } op_e;

   typedef enum logic [3:0] {
      CAUSE_ILLEGAL_INSTR = 4'd2,
      CAUSE_BREAKPOINT    = 4'd3
   } cause_e;

   // one instruction as seen at the commit stage
   typedef struct packed {
      op_e      op;
      reg_idx_t rd;
      reg_idx_t rs1;
      imm_t     imm;
      addr_t    pc;
      logic     trapped;
   } commit_t;

   // classified commit, valid for a single cycle
   typedef struct packed {
      logic  valid;
      logic  is_call;
      logic  is_ret;
      logic  is_nop;
      logic  args_ok;
      addr_t pc;
   } decoded_t;

   typedef struct packed {
      logic   valid;
      cause_e cause;
      addr_t  tval;
   } exception_t;

   typedef struct packed {
      logic  ret_mismatch;
      logic  ss_overflow;
      logic  nop_missing;
      addr_t tval;
   } violation_t;

endpackage

`default_nettype wire

/* verilog/commit_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfi_defs.svh"

module commit_decoder (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              commit_valid_i,
   input  cfi_pkg::commit_t  commit_i,
   input  cfi_pkg::nargs_t   csr_nargs_i,
   output cfi_pkg::decoded_t dec_o
);

   logic             call_d;
   logic             ret_d;
   logic             nop_d;
   logic             args_ok_d;
   cfi_pkg::nargs_t  nop_nargs;

   logic             valid_q;
   logic             call_q;
   logic             ret_q;
   logic             nop_q;
   logic             args_ok_q;
   cfi_pkg::addr_t   pc_q;

   ////////////////////////////////////////////////////////////////////////////
   // instruction classification
   ////////////////////////////////////////////////////////////////////////////

   // calls link through ra, returns jump through ra without linking
   always_comb begin
      call_d = ((commit_i.op == cfi_pkg::OP_JAL) || (commit_i.op == cfi_pkg::OP_JALR)) &&
               (commit_i.rd == cfi_pkg::reg_idx_t'(1));
      ret_d  = (commit_i.op == cfi_pkg::OP_JALR) && (commit_i.rd == '0) &&
               (commit_i.rs1 == cfi_pkg::reg_idx_t'(1));
      nop_d  = (commit_i.op == cfi_pkg::OP_ADD) && (commit_i.rd == '0) &&
               (commit_i.rs1 == '0) && (commit_i.imm[1:0] == `CFI_NOP_IMM_TAG);
   end

   assign nop_nargs = commit_i.imm[`CFI_NOP_ARGS_LSB +: `CFI_ARGS_W];

   // a variadic callee may take more arguments than the caller announced
   always_comb begin
      if (csr_nargs_i == '1) begin
         args_ok_d = 1'b1;
      end else if (commit_i.imm[`CFI_NOP_VARIADIC_BIT]) begin
         args_ok_d = (nop_nargs >= csr_nargs_i);
      end else begin
         args_ok_d = (nop_nargs == csr_nargs_i);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // output register
   ////////////////////////////////////////////////////////////////////////////

   // a trapped instruction never retired, so it produces no pulse
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= commit_valid_i && !commit_i.trapped;
      end
   end

   always_ff @(posedge clk_i) begin
      call_q    <= call_d;
      ret_q     <= ret_d;
      nop_q     <= nop_d;
      args_ok_q <= args_ok_d;
      pc_q      <= commit_i.pc;
   end

   assign dec_o.valid   = valid_q;
   assign dec_o.is_call = call_q;
   assign dec_o.is_ret  = ret_q;
   assign dec_o.is_nop  = nop_q;
   assign dec_o.args_ok = args_ok_q;
   assign dec_o.pc      = pc_q;

endmodule

`default_nettype wire

/* verilog/fwd_edge_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfi_defs.svh"

module fwd_edge_checker (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  cfi_pkg::decoded_t dec_i,
   input  logic              csr_en_i,
   output logic              nop_missing_o,
   output logic              args_clr_o
);

   typedef enum logic {
      IDLE,
      WAIT_NOP
   } fwd_state_e;

   fwd_state_e state_q;
   fwd_state_e state_d;
   logic       nop_missing_d;
   logic       args_clr_d;
   logic       nop_good;

   // the landing instruction must be a tagged nop whose count fits the callee
   assign nop_good = dec_i.is_nop && dec_i.args_ok;

   ////////////////////////////////////////////////////////////////////////////
   // forward edge FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d       = state_q;
      nop_missing_d = 1'b0;
      // the argument register is kept in its reset value while checking is off
      args_clr_d    = !csr_en_i;

      if (dec_i.valid) begin
         case (state_q)
            IDLE: begin
               if (dec_i.is_call) begin
                  state_d = WAIT_NOP;
               end
            end
            WAIT_NOP: begin
               // whatever follows the call consumes the argument count
               args_clr_d = 1'b1;
               if (!nop_good) begin
                  nop_missing_d = 1'b1;
               end
               // a call landing on another call starts a fresh wait
               if (dec_i.is_call) begin
                  state_d = WAIT_NOP;
               end else begin
                  state_d = IDLE;
               end
            end
            default: begin
               state_d = IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q       <= IDLE;
         nop_missing_o <= 1'b0;
         args_clr_o    <= 1'b0;
      end else begin
         state_q       <= state_d;
         nop_missing_o <= nop_missing_d;
         args_clr_o    <= args_clr_d;
      end
   end

endmodule

`default_nettype wire

/* verilog/shadow_stack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfi_defs.svh"

module shadow_stack (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  cfi_pkg::decoded_t dec_i,
   output logic              ret_mismatch_o,
   output logic              ss_overflow_o,
   output cfi_pkg::addr_t    viol_tval_o
);

   localparam int unsigned DEPTH = `CFI_SS_DEPTH;
   localparam int unsigned PTR_W = $clog2(DEPTH + 1);
   localparam int unsigned IDX_W = $clog2(DEPTH);

   typedef enum logic {
      IDLE,
      WAIT_TARGET
   } ss_state_e;

   // ptr_q counts the stored entries, the top sits at ptr_q - 1
   cfi_pkg::addr_t   mem_q [DEPTH];
   logic [PTR_W-1:0] ptr_q;
   logic [PTR_W-1:0] ptr_popped;
   logic [IDX_W-1:0] top_idx;
   logic [IDX_W-1:0] wr_idx;
   cfi_pkg::addr_t   top_addr;
   logic             empty;

   ss_state_e        state_q;
   ss_state_e        state_d;
   logic             pop;
   logic             push;
   logic             mismatch_d;
   logic             overflow_d;

   assign empty    = (ptr_q == '0);
   assign top_idx  = IDX_W'(ptr_q - PTR_W'(1));
   assign top_addr = mem_q[top_idx];

   ////////////////////////////////////////////////////////////////////////////
   // return target FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d    = state_q;
      pop        = 1'b0;
      mismatch_d = 1'b0;

      if (dec_i.valid) begin
         case (state_q)
            IDLE: begin
               if (dec_i.is_ret) begin
                  state_d = WAIT_TARGET;
               end
            end
            WAIT_TARGET: begin
               // the instruction after a return must sit at the saved address
               if (!empty && (top_addr == dec_i.pc)) begin
                  pop = 1'b1;
               end else begin
                  mismatch_d = 1'b1;
               end
               state_d = dec_i.is_ret ? WAIT_TARGET : IDLE;
            end
            default: begin
               state_d = IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // push side, evaluated after any pop of the same cycle
   ////////////////////////////////////////////////////////////////////////////

   assign ptr_popped = ptr_q - PTR_W'(pop);
   assign wr_idx     = IDX_W'(ptr_popped);
   assign push       = dec_i.valid && dec_i.is_call && (ptr_popped != PTR_W'(DEPTH));
   assign overflow_d = dec_i.valid && dec_i.is_call && (ptr_popped == PTR_W'(DEPTH));

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_idx] <= dec_i.pc + cfi_pkg::addr_t'(4);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q        <= IDLE;
         ptr_q          <= '0;
         ret_mismatch_o <= 1'b0;
         ss_overflow_o  <= 1'b0;
      end else begin
         state_q        <= state_d;
         ptr_q          <= ptr_popped + PTR_W'(push);
         ret_mismatch_o <= mismatch_d;
         ss_overflow_o  <= overflow_d;
      end
   end

   // both violations report the pc of the instruction that revealed them
   always_ff @(posedge clk_i) begin
      if (mismatch_d || overflow_d) begin
         viol_tval_o <= dec_i.pc;
      end
   end

endmodule

`default_nettype wire

/* verilog/cfi_exception_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfi_defs.svh"

module cfi_exception_unit (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  cfi_pkg::violation_t viol_i,
   input  logic                csr_en_i,
   output cfi_pkg::exception_t exception_o
);

   localparam int unsigned HOLD  = `CFI_EX_HOLD;
   localparam int unsigned CNT_W = $clog2(HOLD);

   cfi_pkg::exception_t ex_d;
   cfi_pkg::exception_t ex_q;
   logic [CNT_W-1:0]    cnt_q;

   ////////////////////////////////////////////////////////////////////////////
   // violation priority
   ////////////////////////////////////////////////////////////////////////////

   // backward edge faults win over a missing landing nop
   always_comb begin
      ex_d = '0;
      if (csr_en_i) begin
         if (viol_i.ret_mismatch || viol_i.ss_overflow) begin
            ex_d.valid = 1'b1;
            ex_d.cause = cfi_pkg::CAUSE_ILLEGAL_INSTR;
            ex_d.tval  = viol_i.tval;
         end else if (viol_i.nop_missing) begin
            ex_d.valid = 1'b1;
            ex_d.cause = cfi_pkg::CAUSE_BREAKPOINT;
            ex_d.tval  = '0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // hold counter
   ////////////////////////////////////////////////////////////////////////////

   // the record stays up for HOLD cycles, a new fault restarts the count
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         ex_q  <= '0;
         cnt_q <= '0;
      end else begin
         if (ex_d.valid) begin
            ex_q  <= ex_d;
            cnt_q <= CNT_W'(HOLD - 1);
         end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - CNT_W'(1);
         end else begin
            ex_q <= '0;
         end
      end
   end

   assign exception_o = ex_q;

endmodule

`default_nettype wire

/* verilog/cfi_monitor_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfi_defs.svh"

module cfi_monitor_top (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  logic                commit_valid_i,
   input  cfi_pkg::commit_t    commit_i,
   input  logic                csr_en_i,
   input  cfi_pkg::nargs_t     csr_nargs_i,
   output cfi_pkg::exception_t exception_o,
   output logic                args_clr_o
);

   cfi_pkg::decoded_t   dec;
   cfi_pkg::violation_t viol;
   logic                nop_missing;
   logic                ret_mismatch;
   logic                ss_overflow;
   cfi_pkg::addr_t      viol_tval;

   commit_decoder u_commit_decoder (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .commit_valid_i (commit_valid_i),
      .commit_i       (commit_i),
      .csr_nargs_i    (csr_nargs_i),
      .dec_o          (dec)
   );

   fwd_edge_checker u_fwd_edge_checker (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .dec_i         (dec),
      .csr_en_i      (csr_en_i),
      .nop_missing_o (nop_missing),
      .args_clr_o    (args_clr_o)
   );

   shadow_stack u_shadow_stack (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .dec_i          (dec),
      .ret_mismatch_o (ret_mismatch),
      .ss_overflow_o  (ss_overflow),
      .viol_tval_o    (viol_tval)
   );

   // checker pulses travel together to the exception unit
   assign viol.ret_mismatch = ret_mismatch;
   assign viol.ss_overflow  = ss_overflow;
   assign viol.nop_missing  = nop_missing;
   assign viol.tval         = viol_tval;

   cfi_exception_unit u_cfi_exception_unit (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .viol_i      (viol),
      .csr_en_i    (csr_en_i),
      .exception_o (exception_o)
   );

endmodule

`default_nettype wire

/* sim/cfi_monitor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfi_defs.svh"

module cfi_monitor_tb;

   localparam int CLK_PERIOD  = 40;
   localparam int HOLD        = `CFI_EX_HOLD;
   localparam int DEPTH       = `CFI_SS_DEPTH;
   localparam int NUM_TESTS   = 6;
   localparam int TEST_CYCLES = 80;

   logic                clk_i = 1'b0;
   logic                rst_ni;
   logic                commit_valid_i;
   cfi_pkg::commit_t    commit_i;
   logic                csr_en_i;
   cfi_pkg::nargs_t     csr_nargs_i;
   cfi_pkg::exception_t exception_o;
   logic                args_clr_o;

   // reference model state, advanced by the stimulus in program order
   logic                fwd_wait;
   logic                ret_wait;
   cfi_pkg::addr_t      stack_q[$];
   cfi_pkg::exception_t new_ex;
   logic                new_clr;

   // expected outputs, advanced on the clock
   cfi_pkg::exception_t ex_pipe[2];
   logic                clr_pipe;
   cfi_pkg::exception_t exp_ex;
   logic                exp_clr;
   int                  hold_left;
   int                  ex_events = 0;

   int ex_errs = 0;
   int clr_errs = 0;
   int count_errs = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int events_at_start;
   int errors_at_start;

   cfi_monitor_top u_cfi_monitor_top (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .commit_valid_i (commit_valid_i),
      .commit_i       (commit_i),
      .csr_en_i       (csr_en_i),
      .csr_nargs_i    (csr_nargs_i),
      .exception_o    (exception_o),
      .args_clr_o     (args_clr_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   ////////////////////////////////////////////////////////////////////////////
   // expected output timeline
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk_i) begin
      if (!rst_ni) begin
         ex_pipe[0] = '0;
         ex_pipe[1] = '0;
         clr_pipe   = 1'b0;
         exp_ex     = '0;
         exp_clr    = 1'b0;
         hold_left  = 0;
      end else begin
         // a violation shows on exception_o three cycles after its commit
         if (ex_pipe[1].valid && csr_en_i) begin
            exp_ex    = ex_pipe[1];
            hold_left = HOLD;
            ex_events = ex_events + 1;
         end else if (hold_left > 0) begin
            hold_left = hold_left - 1;
            if (hold_left == 0) begin
               exp_ex = '0;
            end
         end
         ex_pipe[1] = ex_pipe[0];
         ex_pipe[0] = new_ex;
         // clear pulse two cycles after the commit that follows a call
         exp_clr  = clr_pipe || !csr_en_i;
         clr_pipe = new_clr;
      end
   end

   // outputs are compared mid cycle, well away from the active edge
   ex_check: assert property (@(negedge clk_i) disable iff (!rst_ni) exception_o == exp_ex)
   else begin
      ex_errs = ex_errs + 1;
      $display("[FAIL] t=%0d ns: exception_o valid=%0b cause=%0d tval=%h, expected %0b %0d %h",
               $time, exception_o.valid, exception_o.cause, exception_o.tval,
               exp_ex.valid, exp_ex.cause, exp_ex.tval);
   end

   clr_check: assert property (@(negedge clk_i) disable iff (!rst_ni) args_clr_o == exp_clr)
   else begin
      clr_errs = clr_errs + 1;
      $display("[FAIL] t=%0d ns: args_clr_o=%0b, expected %0b", $time, args_clr_o, exp_clr);
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic void model_commit(input cfi_pkg::commit_t c);
      logic            is_call;
      logic            is_ret;
      logic            is_nop;
      logic            args_ok;
      logic            mismatch;
      logic            overflow;
      cfi_pkg::nargs_t cnt;
      is_call = ((c.op == cfi_pkg::OP_JAL) || (c.op == cfi_pkg::OP_JALR)) && (c.rd == 5'd1);
      is_ret  = (c.op == cfi_pkg::OP_JALR) && (c.rd == 5'd0) && (c.rs1 == 5'd1);
      is_nop  = (c.op == cfi_pkg::OP_ADD) && (c.rd == 5'd0) && (c.rs1 == 5'd0) &&
                (c.imm[1:0] == 2'd2);
      cnt     = c.imm[10:2];
      if (csr_nargs_i == '1) begin
         args_ok = 1'b1;
      end else if (c.imm[11]) begin
         args_ok = (cnt >= csr_nargs_i);
      end else begin
         args_ok = (cnt == csr_nargs_i);
      end
      new_clr = fwd_wait;
      new_ex  = '0;
      if (fwd_wait && !(is_nop && args_ok)) begin
         new_ex.valid = 1'b1;
         new_ex.cause = cfi_pkg::CAUSE_BREAKPOINT;
      end
      fwd_wait = is_call;
      mismatch = 1'b0;
      if (ret_wait) begin
         if ((stack_q.size() > 0) && (stack_q[$] == c.pc)) begin
            void'(stack_q.pop_back());
         end else begin
            mismatch = 1'b1;
         end
      end
      ret_wait = is_ret;
      // the push of a call is judged after the return check of the same commit
      overflow = 1'b0;
      if (is_call) begin
         if (stack_q.size() == DEPTH) begin
            overflow = 1'b1;
         end else begin
            stack_q.push_back(c.pc + 32'd4);
         end
      end
      if (mismatch || overflow) begin
         new_ex.valid = 1'b1;
         new_ex.cause = cfi_pkg::CAUSE_ILLEGAL_INSTR;
         new_ex.tval  = c.pc;
      end
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic cfi_pkg::addr_t rand_pc();
      logic [31:0] r;
      r = $urandom();
      return cfi_pkg::addr_t'({r[31:2], 2'b00});
   endfunction

   function automatic cfi_pkg::imm_t nop_imm(input logic variadic, input cfi_pkg::nargs_t cnt);
      return {variadic, cnt, `CFI_NOP_IMM_TAG};
   endfunction

   function automatic int total_errors();
      return ex_errs + clr_errs + count_errs;
   endfunction

   task automatic drive_commit(input cfi_pkg::op_e op, input cfi_pkg::reg_idx_t rd,
                               input cfi_pkg::reg_idx_t rs1, input cfi_pkg::imm_t imm,
                               input cfi_pkg::addr_t pc);
      @(posedge clk_i);
      #2;
      commit_valid_i   = 1'b1;
      commit_i.op      = op;
      commit_i.rd      = rd;
      commit_i.rs1     = rs1;
      commit_i.imm     = imm;
      commit_i.pc      = pc;
      commit_i.trapped = 1'b0;
      model_commit(commit_i);
   endtask

   task automatic drive_filler(input cfi_pkg::addr_t pc);
      drive_commit(cfi_pkg::OP_OTHER, cfi_pkg::reg_idx_t'($urandom()),
                   cfi_pkg::reg_idx_t'($urandom()), cfi_pkg::imm_t'($urandom()), pc);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #2;
         commit_valid_i = 1'b0;
         new_ex         = '0;
         new_clr        = 1'b0;
      end
   endtask

   task automatic reset_dut();
      @(posedge clk_i);
      #2;
      rst_ni         = 1'b0;
      commit_valid_i = 1'b0;
      new_ex         = '0;
      new_clr        = 1'b0;
      fwd_wait       = 1'b0;
      ret_wait       = 1'b0;
      stack_q.delete();
      repeat (3) @(posedge clk_i);
      #2;
      rst_ni = 1'b1;
   endtask

   task automatic begin_test();
      events_at_start = ex_events;
      errors_at_start = total_errors();
      reset_dut();
   endtask

   task automatic end_test(input string name, input int expected);
      int raised;
      int errs;
      idle_cycles(HOLD + 6);
      raised = ex_events - events_at_start;
      count_check: assert (raised == expected)
      else begin
         count_errs = count_errs + 1;
         $display("[FAIL] t=%0d ns: %s raised %0d exceptions, expected %0d",
                  $time, name, raised, expected);
      end
      errs = total_errors() - errors_at_start;
      if (errs == 0) begin
         tests_passed = tests_passed + 1;
         $display("test %0d %s: ok", tests_passed + tests_failed, name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %0d %s: failed with %0d errors", tests_passed + tests_failed, name, errs);
      end
   endtask

   task automatic indirect_call(input cfi_pkg::nargs_t n, input cfi_pkg::imm_t imm);
      csr_nargs_i = n;
      drive_commit(cfi_pkg::OP_JALR, 5'd1, cfi_pkg::reg_idx_t'($urandom()), '0, rand_pc());
      drive_commit(cfi_pkg::OP_ADD, 5'd0, 5'd0, imm, rand_pc());
      idle_cycles(1);
      csr_nargs_i = '1;
      idle_cycles(2);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_call_nop_return();
      cfi_pkg::addr_t call_pc;
      cfi_pkg::addr_t body_pc;
      begin_test();
      call_pc = rand_pc();
      body_pc = rand_pc();
      drive_commit(cfi_pkg::OP_JAL, 5'd1, 5'd0, '0, call_pc);
      drive_commit(cfi_pkg::OP_ADD, 5'd0, 5'd0, nop_imm(1'b0, '0), body_pc);
      drive_filler(body_pc + 32'd4);
      drive_commit(cfi_pkg::OP_JALR, 5'd0, 5'd1, '0, body_pc + 32'd8);
      drive_filler(call_pc + 32'd4);
      end_test("call, nop and return", 0);
   endtask

   task automatic test_missing_nop();
      begin_test();
      drive_commit(cfi_pkg::OP_JAL, 5'd1, 5'd0, '0, rand_pc());
      drive_filler(rand_pc());
      end_test("missing nop", 1);
   endtask

   task automatic test_indirect_args();
      cfi_pkg::nargs_t n;
      cfi_pkg::nargs_t extra;
      begin_test();
      n = cfi_pkg::nargs_t'($urandom_range(1, 200));
      indirect_call(n, nop_imm(1'b0, n));
      // variadic callee taking more than announced
      n     = cfi_pkg::nargs_t'($urandom_range(1, 200));
      extra = cfi_pkg::nargs_t'($urandom_range(1, 50));
      indirect_call(n, nop_imm(1'b1, n + extra));
      n     = cfi_pkg::nargs_t'($urandom_range(1, 200));
      extra = cfi_pkg::nargs_t'($urandom_range(1, 50));
      indirect_call(n, nop_imm(1'b0, n + extra));
      // a variadic callee still needs at least the announced count
      n     = cfi_pkg::nargs_t'($urandom_range(1, 200));
      extra = cfi_pkg::nargs_t'($urandom_range(1, n));
      indirect_call(n, nop_imm(1'b1, n - extra));
      end_test("indirect call argument counts", 2);
   endtask

   task automatic test_bad_return();
      cfi_pkg::addr_t call_pc;
      begin_test();
      drive_commit(cfi_pkg::OP_JALR, 5'd0, 5'd1, '0, rand_pc());
      drive_filler(rand_pc());
      idle_cycles(2);
      call_pc = rand_pc();
      drive_commit(cfi_pkg::OP_JAL, 5'd1, 5'd0, '0, call_pc);
      drive_commit(cfi_pkg::OP_ADD, 5'd0, 5'd0, nop_imm(1'b0, '0), rand_pc());
      drive_commit(cfi_pkg::OP_JALR, 5'd0, 5'd1, '0, rand_pc());
      drive_filler(call_pc + 32'd12);
      end_test("wrong return target", 2);
   endtask

   task automatic test_stack_overflow();
      cfi_pkg::addr_t call_pcs[DEPTH + 1];
      int             i;
      begin_test();
      for (i = 0; i <= DEPTH; i++) begin
         call_pcs[i] = rand_pc();
         drive_commit(cfi_pkg::OP_JAL, 5'd1, 5'd0, '0, call_pcs[i]);
         drive_commit(cfi_pkg::OP_ADD, 5'd0, 5'd0, nop_imm(1'b0, '0), rand_pc());
      end
      // the deepest call was never stored, unwinding starts one level up
      for (i = DEPTH - 1; i >= 0; i--) begin
         drive_commit(cfi_pkg::OP_JALR, 5'd0, 5'd1, '0, rand_pc());
         drive_filler(call_pcs[i] + 32'd4);
      end
      end_test("shadow stack overflow", 1);
   endtask

   task automatic test_checks_off();
      csr_en_i = 1'b0;
      begin_test();
      drive_commit(cfi_pkg::OP_JALR, 5'd0, 5'd1, '0, rand_pc());
      drive_filler(rand_pc());
      drive_commit(cfi_pkg::OP_JAL, 5'd1, 5'd0, '0, rand_pc());
      drive_filler(rand_pc());
      idle_cycles(4);
      csr_en_i = 1'b1;
      end_test("checking disabled", 0);
   endtask

   initial begin
      rst_ni         = 1'b0;
      commit_valid_i = 1'b0;
      commit_i       = '0;
      csr_en_i       = 1'b1;
      csr_nargs_i    = '1;
      new_ex         = '0;
      new_clr        = 1'b0;
      fwd_wait       = 1'b0;
      ret_wait       = 1'b0;
      void'($urandom(32'h34b2e0c9));
      test_call_nop_return();
      test_missing_nop();
      test_indirect_args();
      test_bad_return();
      test_stack_overflow();
      test_checks_off();
      $display("%0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, total_errors());
      if (total_errors() == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog sized from the longest test times the number of tests
   initial begin
      #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + 100));
      $display("timeout: the tests did not finish in the expected number of cycles");
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* cfi_monitor_top.f */
+incdir+verilog
verilog/cfi_pkg.sv
verilog/commit_decoder.sv
verilog/fwd_edge_checker.sv
verilog/shadow_stack.sv
verilog/cfi_exception_unit.sv
verilog/cfi_monitor_top.sv
sim/cfi_monitor_tb.sv

/* Makefile */
SIM      := verilator
VFLAGS   := --binary --assert --timing
TOP      := cfi_monitor_tb
FILELIST := cfi_monitor_top.f
OBJ_DIR  := obj_dir
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
